// File: hw/execStateResolver.sv
/*
  Builds the active-list record and outgoing branch result from the
  held entry. Purely combinational. Targets must be 4-byte aligned,
  anything else on a valid branch is a misaligned fault.
*/
`timescale 1ns/1ps
`default_nettype none

module execStateResolver (
    input  wire wbPipeTypesPkg::execResultS held,
    input  wire logic                       update,
    output logic                            alWrite,
    output wbCommitTypesPkg::alRecordS      alRecord,
    output wbPipeTypesPkg::branchResultS    brOut
);

    wbPipeTypesPkg::branchResultS br;
    wbCommitTypesPkg::execStateE  state;

    always_comb begin
        br       = held.brResult;
        // Branch outcome only counts once the op really completes
        br.valid = held.brResult.valid && update && held.dataValid;
    end

    always_comb begin
        if (update && held.dataValid) begin
            state = held.brMissPred ? wbCommitTypesPkg::execRefetchNext :
                                      wbCommitTypesPkg::execSuccess;
        end else begin
            state = wbCommitTypesPkg::execNotFinished;
        end
    end

    always_comb begin
        alRecord.ptr      = held.iqData.alPtr;
        alRecord.isBranch = held.iqData.opType inside {
            wbPipeTypesPkg::opBranch, wbPipeTypesPkg::opIndJump
        };
        alRecord.brResult = br;

        // Conditional branches shift in their own direction
        if (br.isCondBr) begin
            alRecord.brHistory = {br.globalHistory[6:0], br.execTaken};
        end else begin
            alRecord.brHistory = br.globalHistory;
        end

        alRecord.state          = state;
        alRecord.payload.nextPc = br.nextAddr;
        if ((state inside {wbCommitTypesPkg::execSuccess, wbCommitTypesPkg::execRefetchNext})
                && br.valid && (br.nextAddr[1:0] != 2'b00)) begin
            alRecord.state             = wbCommitTypesPkg::execFaultMisaligned;
            alRecord.payload.faultAddr = br.nextAddr;
        end
    end

    assign alWrite = update;
    assign brOut   = br;

endmodule

`default_nettype wire

// File: hw/intWb_consts.svh
/*
  Sizing constants for the integer write-back stage.
  INTWB_PREG_BITS must cover INTWB_PREG_NUM registers, and
  INTWB_REPLAY_DEPTH must be a power of two for the replay pointers.
*/
`ifndef INTWB_CONSTS_SVH
`define INTWB_CONSTS_SVH

// Data word and instruction address width
`define INTWB_DATA_WIDTH 32

// Physical integer registers
`define INTWB_PREG_NUM 64
`define INTWB_PREG_BITS 6

// Active-list pointer, wraps at 2**5 entries
`define INTWB_AL_PTR_BITS 5

// Replay queue entries
`define INTWB_REPLAY_DEPTH 4

`endif

// File: hw/intWriteBackUnit.sv
/*
  Integer write-back top, single lane.
  Active list, scheduler and fetch sit outside and see only the
  record, branch result and replay ports.
*/
`timescale 1ns/1ps
`default_nettype none

`include "intWb_consts.svh"

module intWriteBackUnit (
    input  wire logic                           ctrl,
    input  wire logic                           arstN,
    input  wire wbPipeTypesPkg::execResultS     exIn,
    input  wire logic                           stall,
    input  wire logic                           clear,
    input  wire wbPipeTypesPkg::recoveryS       recovery,
    input  wire logic                           replayPop,
    input  wire logic [`INTWB_PREG_BITS-1:0]    rfReadNum,
    output logic                                alWrite,
    output wbCommitTypesPkg::alRecordS          alRecord,
    output wbPipeTypesPkg::branchResultS        brOut,
    output logic                                replayValid,
    output wbCommitTypesPkg::replayRecordS      replayHead,
    output logic                                replayFull,
    output logic [`INTWB_DATA_WIDTH-1:0]        rfReadData
);

    wbPipeTypesPkg::execResultS held;
    logic                       update;
    logic                       rfWrite;
    logic                       replayPush;

    wbControl control (
        .ctrl       (ctrl),
        .arstN      (arstN),
        .exIn       (exIn),
        .stall      (stall),
        .clear      (clear),
        .recovery   (recovery),
        .replayFull (replayFull),
        .held       (held),
        .update     (update),
        .rfWrite    (rfWrite),
        .replayPush (replayPush)
    );

    physRegFile regFile (
        .ctrl   (ctrl),
        .arstN  (arstN),
        .wrEn   (rfWrite),
        .wrNum  (held.iqData.phyDstNum),
        .wrData (held.data),
        .rdNum  (rfReadNum),
        .rdData (rfReadData)
    );

    execStateResolver resolver (
        .held     (held),
        .update   (update),
        .alWrite  (alWrite),
        .alRecord (alRecord),
        .brOut    (brOut)
    );

    replayQueue replay (
        .ctrl      (ctrl),
        .arstN     (arstN),
        .push      (replayPush),
        .pushData  (held.iqData),
        .pop       (replayPop),
        .headValid (replayValid),
        .head      (replayHead),
        .full      (replayFull)
    );

endmodule

`default_nettype wire

// File: hw/physRegFile.sv
/*
  Physical integer register file, one write port and one read port.
  Write lands at the clock edge, read is combinational, so a write
  shows on rdData the cycle after it.
*/
`timescale 1ns/1ps
`default_nettype none

`include "intWb_consts.svh"

module physRegFile (
    input  wire logic                         ctrl,
    input  wire logic                         arstN,
    input  wire logic                         wrEn,
    input  wire logic [`INTWB_PREG_BITS-1:0]  wrNum,
    input  wire logic [`INTWB_DATA_WIDTH-1:0] wrData,
    input  wire logic [`INTWB_PREG_BITS-1:0]  rdNum,
    output logic [`INTWB_DATA_WIDTH-1:0]      rdData
);

    logic [`INTWB_DATA_WIDTH-1:0] regs [`INTWB_PREG_NUM];

    always_ff @(posedge ctrl or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < `INTWB_PREG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn) begin
            regs[wrNum] <= wrData;
        end
    end

    // Observation port, later also operand reads
    assign rdData = regs[rdNum];

endmodule

`default_nettype wire

// File: hw/replayQueue.sv
/*
  Circular FIFO for ops whose execution did not finish.
  Push on a full queue is dropped unless a pop happens in the same
  cycle, pop on an empty queue is ignored.
*/
`timescale 1ns/1ps
`default_nettype none

`include "intWb_consts.svh"

module replayQueue (
    input  wire logic                           ctrl,
    input  wire logic                           arstN,
    input  wire logic                           push,
    input  wire wbCommitTypesPkg::replayRecordS pushData,
    input  wire logic                           pop,
    output logic                                headValid,
    output wbCommitTypesPkg::replayRecordS      head,
    output logic                                full
);

    localparam int PtrBits = $clog2(`INTWB_REPLAY_DEPTH);

    wbCommitTypesPkg::replayRecordS entries [`INTWB_REPLAY_DEPTH];
    logic [PtrBits-1:0] rdPtr;
    logic [PtrBits-1:0] wrPtr;
    logic [PtrBits:0]   count;
    logic               doPush;
    logic               doPop;

    assign doPop  = pop && (count != '0);
    assign doPush = push && (!full || doPop);

    always_ff @(posedge ctrl or negedge arstN) begin
        if (!arstN) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= rdPtr + 1'b1;
            end
            // Simultaneous push and pop leave the count alone
            if (doPush && !doPop) begin
                count <= count + 1'b1;
            end else if (doPop && !doPush) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge ctrl) begin
        if (doPush) begin
            entries[wrPtr] <= pushData;
        end
    end

    assign headValid = (count != '0);
    assign head      = entries[rdPtr];
    assign full      = (count == (PtrBits + 1)'(`INTWB_REPLAY_DEPTH));

endmodule

`default_nettype wire

// File: hw/wbCommitTypesPkg.sv
/*
  Types for what write-back sends toward commit and replay.
  The payload word is read as next PC or fault address depending
  on the execution state.
*/
`default_nettype none

`include "intWb_consts.svh"

package wbCommitTypesPkg;

    typedef enum logic [1:0] {
        execNotFinished     = 2'd0,
        execSuccess         = 2'd1,
        execRefetchNext     = 2'd2,
        execFaultMisaligned = 2'd3
    } execStateE;

    // Same word, two readings
    typedef union packed {
        logic [`INTWB_DATA_WIDTH-1:0] nextPc;
        logic [`INTWB_DATA_WIDTH-1:0] faultAddr;
    } alPayloadU;

    typedef struct packed {
        wbPipeTypesPkg::alPtrT         ptr;
        execStateE                     state;
        logic                          isBranch;
        wbPipeTypesPkg::globalHistoryT brHistory;
        alPayloadU                     payload;
        wbPipeTypesPkg::branchResultS  brResult;
    } alRecordS;

    // Replay port carries the issue-queue entry unchanged
    typedef wbPipeTypesPkg::intQueueDataS replayRecordS;

endpackage

`default_nettype wire

// File: hw/wbControl.sv
/*
  Pipeline register and commit decision for the write-back stage.
  A full replay queue acts like an external stall. Clear only kills
  the strobes, the held entry stays.
*/
`timescale 1ns/1ps
`default_nettype none

module wbControl (
    input  wire logic                       ctrl,
    input  wire logic                       arstN,
    input  wire wbPipeTypesPkg::execResultS exIn,
    input  wire logic                       stall,
    input  wire logic                       clear,
    input  wire wbPipeTypesPkg::recoveryS   recovery,
    input  wire logic                       replayFull,
    output wbPipeTypesPkg::execResultS      held,
    output logic                            update,
    output logic                            rfWrite,
    output logic                            replayPush
);

    logic                       heldValid;
    wbPipeTypesPkg::execResultS heldData;
    logic                       effStall;
    logic                       flushed;

    // Circular range test, head inclusive and tail exclusive
    function automatic logic inFlushRange(
        input wbPipeTypesPkg::alPtrT head,
        input wbPipeTypesPkg::alPtrT tail,
        input wbPipeTypesPkg::alPtrT ptr
    );
        logic hit;
        if (head <= tail) begin
            hit = (ptr >= head) && (ptr < tail);
        end else begin
            // Wrapped range
            hit = (ptr >= head) || (ptr < tail);
        end
        return hit;
    endfunction

    assign effStall = stall || replayFull;

    always_ff @(posedge ctrl or negedge arstN) begin
        if (!arstN) begin
            heldValid <= 1'b0;
        end else if (!effStall) begin
            heldValid <= exIn.valid;
        end
    end

    // Payload only, valid lives in heldValid
    always_ff @(posedge ctrl) begin
        if (!effStall) begin
            heldData <= exIn;
        end
    end

    always_comb begin
        held       = heldData;
        held.valid = heldValid;
    end

    always_comb begin
        flushed = 1'b0;
        if (recovery.toRecoveryPhase) begin
            flushed = recovery.flushAll ||
                inFlushRange(recovery.flushHead, recovery.flushTail, heldData.iqData.alPtr);
        end
    end

    assign update = heldValid && !effStall && !clear && !flushed;

    // Unfinished results go to replay, never into the register file
    assign rfWrite    = update && heldData.iqData.writeReg && heldData.dataValid;
    assign replayPush = update && !heldData.dataValid;

endmodule

`default_nettype wire

// File: hw/wbPipeTypesPkg.sv
/*
  Types for what the integer execution stage hands to write-back.
  One lane only. Global history is fixed at 8 bits.
*/
`default_nettype none

`include "intWb_consts.svh"

package wbPipeTypesPkg;

    // Integer op class
    typedef enum logic [1:0] {
        opAlu     = 2'd0,
        opBranch  = 2'd1,
        opIndJump = 2'd2,
        opShift   = 2'd3
    } opTypeE;

    typedef logic [7:0] globalHistoryT;
    typedef logic [5:0] opIdT;
    typedef logic [`INTWB_AL_PTR_BITS-1:0] alPtrT;
    typedef logic [`INTWB_PREG_BITS-1:0] pregNumT;
    typedef logic [`INTWB_DATA_WIDTH-1:0] dataWordT;

    // Issue-queue entry, also what gets replayed
    typedef struct packed {
        opTypeE  opType;
        logic    writeReg;
        pregNumT phyDstNum;
        alPtrT   alPtr;
        opIdT    opId;
    } intQueueDataS;

    typedef struct packed {
        logic          valid;
        logic          isCondBr;
        logic          execTaken;
        dataWordT      nextAddr;
        globalHistoryT globalHistory;
    } branchResultS;

    typedef struct packed {
        logic         valid;
        logic         dataValid;
        logic         brMissPred;
        dataWordT     data;
        branchResultS brResult;
        intQueueDataS iqData;
    } execResultS;

    // Flush range is head inclusive, tail exclusive
    typedef struct packed {
        logic  toRecoveryPhase;
        logic  flushAll;
        alPtrT flushHead;
        alPtrT flushTail;
    } recoveryS;

endpackage

`default_nettype wire

// File: src.f
+incdir+hw
hw/wbPipeTypesPkg.sv
hw/wbCommitTypesPkg.sv
hw/wbControl.sv
hw/physRegFile.sv
hw/execStateResolver.sv
hw/replayQueue.sv
hw/intWriteBackUnit.sv
testbench/intWb_properties.sv
testbench/intWbTb.sv

// File: testbench/intWbTb.sv
/*
  Testbench for the integer write-back unit, one operation per vector.
  Vectors are read from testbench/intWb_input.txt relative to the
  project root. Stall lengths between operations are random.
*/
`timescale 1ns/1ps
`default_nettype none

`include "intWb_consts.svh"

module intWbTb;

    localparam int NumOps  = 18;
    localparam int NumCols = 14;

    logic                           ctrl = 1'b0;
    logic                           arstN;
    wbPipeTypesPkg::execResultS     exIn;
    logic                           stall;
    logic                           clear;
    wbPipeTypesPkg::recoveryS       recovery;
    logic                           replayPop;
    logic [`INTWB_PREG_BITS-1:0]    rfReadNum;
    logic                           alWrite;
    wbCommitTypesPkg::alRecordS     alRecord;
    wbPipeTypesPkg::branchResultS   brOut;
    logic                           replayValid;
    wbCommitTypesPkg::replayRecordS replayHead;
    logic                           replayFull;
    logic [`INTWB_DATA_WIDTH-1:0]   rfReadData;

    logic [31:0]                    vectors [NumOps*NumCols];
    logic [`INTWB_DATA_WIDTH-1:0]   regModel [`INTWB_PREG_NUM];
    wbCommitTypesPkg::replayRecordS replayModel [$];
    int                             checks;
    int                             errors;
    int                             timeouts;

    intWriteBackUnit uut (
        .ctrl        (ctrl),
        .arstN       (arstN),
        .exIn        (exIn),
        .stall       (stall),
        .clear       (clear),
        .recovery    (recovery),
        .replayPop   (replayPop),
        .rfReadNum   (rfReadNum),
        .alWrite     (alWrite),
        .alRecord    (alRecord),
        .brOut       (brOut),
        .replayValid (replayValid),
        .replayHead  (replayHead),
        .replayFull  (replayFull),
        .rfReadData  (rfReadData)
    );

    always #4 ctrl = ~ctrl;

    // Column c of operation idx
    function automatic logic [31:0] vecField(input int idx, input int c);
        return vectors[idx*NumCols + c];
    endfunction

    function automatic wbPipeTypesPkg::execResultS buildExec(input int idx);
        wbPipeTypesPkg::execResultS e;
        logic [31:0]                flg;
        flg = vecField(idx, 1);
        e = '0;
        e.valid                   = 1'b1;
        e.dataValid               = flg[0];
        e.brMissPred              = flg[1];
        e.data                    = vecField(idx, 4);
        e.brResult.valid          = flg[3];
        e.brResult.isCondBr       = flg[4];
        e.brResult.execTaken      = flg[5];
        e.brResult.nextAddr       = vecField(idx, 5);
        e.brResult.globalHistory  = wbPipeTypesPkg::globalHistoryT'(vecField(idx, 6));
        e.iqData.opType           = wbPipeTypesPkg::opTypeE'(vecField(idx, 0) & 32'h3);
        e.iqData.writeReg         = flg[2];
        e.iqData.phyDstNum        = wbPipeTypesPkg::pregNumT'(vecField(idx, 2));
        e.iqData.alPtr            = wbPipeTypesPkg::alPtrT'(vecField(idx, 3));
        // Op id tags each entry for the replay order check
        e.iqData.opId             = wbPipeTypesPkg::opIdT'(idx);
        return e;
    endfunction

    task automatic expectValue(input string name, input logic [31:0] act,
                               input logic [31:0] exp);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("Fail %s: expected 0x%h, got 0x%h", name, exp, act);
        end
    endtask

    task automatic checkReplayPort();
        expectValue("replayValid", replayValid, replayModel.size() != 0);
        expectValue("replayFull", replayFull, replayModel.size() == `INTWB_REPLAY_DEPTH);
        if (replayModel.size() != 0) begin
            expectValue("replayHead", replayHead, replayModel[0]);
        end
    endtask

    task automatic compareRecord(input int idx);
        logic [31:0] flg;
        logic [31:0] op;
        logic        wr;
        logic [31:0] payload;
        flg = vecField(idx, 1);
        op  = vecField(idx, 0);
        wr  = (vecField(idx, 13) != 0);
        // Payload reading follows the expected state
        if (vecField(idx, 10) == 32'd3) begin
            payload = alRecord.payload.faultAddr;
        end else begin
            payload = alRecord.payload.nextPc;
        end
        expectValue("alWrite", alWrite, wr);
        expectValue("alRecord.state", alRecord.state, vecField(idx, 10));
        expectValue("alRecord.brHistory", alRecord.brHistory, vecField(idx, 11));
        expectValue("alRecord.payload", payload, vecField(idx, 12));
        expectValue("alRecord.ptr", alRecord.ptr, vecField(idx, 3));
        expectValue("alRecord.isBranch", alRecord.isBranch, (op == 32'd1) || (op == 32'd2));
        expectValue("alRecord.brResult.valid", alRecord.brResult.valid,
                    flg[3] && flg[0] && wr);
        expectValue("alRecord.brResult.nextAddr", alRecord.brResult.nextAddr,
                    vecField(idx, 5));
        expectValue("brOut.valid", brOut.valid, flg[3] && flg[0] && wr);
        expectValue("brOut.isCondBr", brOut.isCondBr, flg[4]);
        expectValue("brOut.execTaken", brOut.execTaken, flg[5]);
        expectValue("brOut.nextAddr", brOut.nextAddr, vecField(idx, 5));
        expectValue("brOut.globalHistory", brOut.globalHistory, vecField(idx, 6));
    endtask

    task automatic updateModels(input int idx);
        wbPipeTypesPkg::execResultS e;
        e = buildExec(idx);
        if (vecField(idx, 13) != 0) begin
            if (e.dataValid && e.iqData.writeReg) begin
                regModel[e.iqData.phyDstNum] = e.data;
            end
            if (!e.dataValid) begin
                replayModel.push_back(e.iqData);
            end
        end
    endtask

    initial begin
        int          stallCycles;
        int          guard;
        logic [31:0] rcv;
        void'($urandom(50));
        checks    = 0;
        errors    = 0;
        timeouts  = 0;
        arstN     = 1'b0;
        exIn      = '0;
        stall     = 1'b0;
        clear     = 1'b0;
        recovery  = '0;
        replayPop = 1'b0;
        rfReadNum = '0;
        for (int r = 0; r < `INTWB_PREG_NUM; r++) begin
            regModel[r] = '0;
        end
        $readmemh("testbench/intWb_input.txt", vectors);

        repeat (2) @(negedge ctrl);
        expectValue("alWrite", alWrite, 1'b0);
        expectValue("brOut.valid", brOut.valid, 1'b0);
        checkReplayPort();
        arstN = 1'b1;
        exIn  = buildExec(0);

        for (int i = 0; i < NumOps && timeouts == 0; i++) begin
            @(negedge ctrl);
            // Previous op's register write is visible by now
            expectValue("rfReadData", rfReadData, regModel[rfReadNum]);
            clear = 1'b0;
            stallCycles = $urandom_range(0, 2);
            repeat (stallCycles) begin
                stall = 1'b1;
                #2;
                expectValue("alWrite", alWrite, 1'b0);
                expectValue("brOut.valid", brOut.valid, 1'b0);
                @(negedge ctrl);
            end
            rcv = vecField(i, 7);
            stall                    = 1'b0;
            clear                    = rcv[2];
            recovery.toRecoveryPhase = rcv[0];
            recovery.flushAll        = rcv[1];
            recovery.flushHead       = wbPipeTypesPkg::alPtrT'(vecField(i, 8));
            recovery.flushTail       = wbPipeTypesPkg::alPtrT'(vecField(i, 9));
            rfReadNum                = wbPipeTypesPkg::pregNumT'(vecField(i, 2));
            if (i + 1 < NumOps) begin
                exIn = buildExec(i + 1);
            end else begin
                exIn = '0;
            end
            #2;
            checkReplayPort();

            // Full replay queue holds the entry until a pop
            guard = 0;
            while (replayFull && timeouts == 0) begin
                expectValue("alWrite", alWrite, 1'b0);
                @(negedge ctrl);
                replayPop = 1'b1;
                @(negedge ctrl);
                replayPop = 1'b0;
                void'(replayModel.pop_front());
                #2;
                checkReplayPort();
                guard++;
                if (guard >= 4) begin
                    timeouts++;
                    $display("Timeout: replay queue stayed full while op %0d was held", i);
                end
            end
            if (timeouts == 0) begin
                compareRecord(i);
                updateModels(i);
            end
        end

        if (timeouts == 0) begin
            @(negedge ctrl);
            expectValue("rfReadData", rfReadData, regModel[rfReadNum]);
            // Remaining entries leave in push order
            while (replayModel.size() != 0) begin
                checkReplayPort();
                replayPop = 1'b1;
                @(negedge ctrl);
                void'(replayModel.pop_front());
            end
            replayPop = 1'b0;
            checkReplayPort();
        end

        $display("Checks: %0d, errors: %0d, assertion failures: %0d, timeouts: %0d",
                 checks, errors, uut.control.controlChecks.failures, timeouts);
        if (errors == 0 && timeouts == 0 && uut.control.controlChecks.failures == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/intWb_input.txt
// op flags dst alPtr data nextAddr history recov head tail | expected: state history payload alWrite
// flags b0 dataValid b1 brMissPred b2 writeReg b3 brValid b4 isCondBr b5 execTaken, recov b0 recovery b1 flushAll b2 clear
0 05 03 00 1234abcd 00000104 00 0 00 00 1 00 00000104 1
3 05 0a 01 cafe0001 00000108 5a 0 00 00 1 5a 00000108 1
1 39 00 02 00000000 00000200 5a 0 00 00 1 b5 00000200 1
1 1b 00 03 00000000 00000300 b5 0 00 00 2 6a 00000300 1
1 3b 00 04 00000000 00000410 0f 0 00 00 2 1f 00000410 1
2 0d 05 05 00000130 00001002 33 0 00 00 3 33 00001002 1
0 05 07 06 77777777 00000500 00 1 04 08 0 00 00000500 0
0 05 08 08 88888888 00000504 00 1 04 08 1 00 00000504 1
0 05 09 1e 99999999 00000508 00 1 1c 03 0 00 00000508 0
0 05 0b 03 bbbb0003 0000050c 00 1 1c 03 1 00 0000050c 1
0 05 0c 0a cccccccc 00000510 00 3 00 00 0 00 00000510 0
1 3d 0d 0b dddd0000 00000600 10 4 00 00 0 21 00000600 0
0 04 10 0c 00000000 00000700 00 0 00 00 0 00 00000700 1
3 04 11 0d 00000000 00000704 44 0 00 00 0 44 00000704 1
1 38 00 0e 00000000 00000800 01 0 00 00 0 03 00000800 1
0 04 12 0f 00000000 00000708 00 0 00 00 0 00 00000708 1
0 05 13 10 13131313 0000070c 00 0 00 00 1 00 0000070c 1
0 04 14 11 00000000 00000710 00 0 00 00 0 00 00000710 1

// File: testbench/intWb_properties.sv
/*
  Concurrent checks on the write-back control, bound into wbControl.
  All checks are disabled while arstN is low.
*/
`timescale 1ns/1ps
`default_nettype none

module wbControlChecks (
    input wire logic                       ctrl,
    input wire logic                       arstN,
    input wire logic                       stall,
    input wire logic                       clear,
    input wire logic                       replayFull,
    input wire wbPipeTypesPkg::execResultS held,
    input wire logic                       update,
    input wire logic                       rfWrite,
    input wire logic                       replayPush
);

    int failures = 0;

    // Stall and clear kill every strobe
    noStrobeWhenBlocked: assert property (@(posedge ctrl) disable iff (!arstN)
        (stall || clear) |-> !(update || rfWrite || replayPush))
        else begin
            failures++;
            $error("strobe fired during stall or clear");
        end

    rfWriteNeedsUpdate: assert property (@(posedge ctrl) disable iff (!arstN)
        rfWrite |-> update)
        else begin
            failures++;
            $error("rfWrite without update");
        end

    // Pipeline register holds through any stall
    heldStableWhileStalled: assert property (@(posedge ctrl) disable iff (!arstN)
        (stall || replayFull) |=> $stable(held))
        else begin
            failures++;
            $error("held entry changed during a stall");
        end

    noWriteAndReplay: assert property (@(posedge ctrl) disable iff (!arstN)
        !(rfWrite && replayPush))
        else begin
            failures++;
            $error("rfWrite and replayPush fired together");
        end

endmodule

bind wbControl wbControlChecks controlChecks (
    .ctrl       (ctrl),
    .arstN      (arstN),
    .stall      (stall),
    .clear      (clear),
    .replayFull (replayFull),
    .held       (held),
    .update     (update),
    .rfWrite    (rfWrite),
    .replayPush (replayPush)
);

`default_nettype wire
